// File: design/aluUnit.sv
/*
 * ALU class: arithmetic, logic, rotate and register moves on A and B,
 * with the flag results of each operation
 */
`timescale 1ns/1ps
`default_nettype none

module aluUnit import sMachinePkg::*; (
    input  instrT    instr,
    input  regStateT cur,
    output regStateT aluNext
);

    dataT sum;
    dataT diff;
    dataT logicRes;
    dataT rotRes;

    assign sum    = cur.a + cur.b;
    assign diff   = cur.a - cur.b;
    assign rotRes = {cur.a[0], cur.a[dataWidth-1:1]};

    // Bitwise result for OR, AND and XOR
    always_comb begin
        case (instr.alu.aluOp)
            aluOr:   logicRes = cur.a | cur.b;
            aluAnd:  logicRes = cur.a & cur.b;
            default: logicRes = cur.a ^ cur.b;
        endcase
    end

    always_comb begin
        aluNext = cur;
        case (instr.alu.aluOp)
            aluAdd: begin
                aluNext.a     = sum;
                aluNext.flags = arithFlags(cur.a, cur.b, sum);
            end
            aluSub: begin
                aluNext.a     = diff;
                aluNext.flags = arithFlags(cur.a, cur.b, diff);
            end
            aluOr, aluAnd, aluXor: begin
                aluNext.a     = logicRes;
                aluNext.flags = resultFlags(logicRes, 1'b0);
            end
            // Rotate right with the LSB wrapping into the MSB
            aluShr: begin
                aluNext.a = rotRes;
            end
            aluMov: begin
                aluNext.b = cur.a;
            end
            aluExch: begin
                aluNext.a = cur.b;
                aluNext.b = cur.a;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: design/fetchUnit.sv
/*
 * Program counter. Steps by one each cycle, or loads the
 * instruction's address field on a taken branch
 */
`timescale 1ns/1ps
`default_nettype none

module fetchUnit import sMachinePkg::*; (
    input  logic  clk,
    input  logic  rstN,
    input  instrT instr,
    input  logic  branchTaken,
    output addrT  pc
);

    addrT pcNext;

    // Branch target comes straight from the memory-format word
    always_comb begin
        if (branchTaken) begin
            pcNext = instr.mem.addr;
        end else begin
            pcNext = pc + addrT'(1);
        end
    end

    // Wraps naturally at 256
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

endmodule

`default_nettype wire

// File: design/flagUnit.sv
/*
 * Flag class: compare A with B, set or clear masked flags
 */
`timescale 1ns/1ps
`default_nettype none

module flagUnit import sMachinePkg::*; (
    input  instrT    instr,
    input  regStateT cur,
    output regStateT flagNext
);

    dataT  diff;
    flagsT cmpFlags;

    // Same flag rule as SUB, result discarded
    assign diff     = cur.a - cur.b;
    assign cmpFlags = arithFlags(cur.a, cur.b, diff);

    always_comb begin
        flagNext = cur;
        case (instr.flg.flagOp)
            flagCmp: begin
                flagNext.flags = cmpFlags;
            end
            flagSet: begin
                flagNext.flags = cur.flags | instr.flg.mask;
            end
            flagClr: begin
                flagNext.flags = cur.flags & ~instr.flg.mask;
            end
            default: begin
                flagNext.flags = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: design/memUnit.sv
/*
 * Memory and branch class: 256-word data RAM with load, store and
 * immediate increment, plus the conditional branch decision
 */
`timescale 1ns/1ps
`default_nettype none

module memUnit import sMachinePkg::*; (
    input  logic     clk,
    input  instrT    instr,
    input  regStateT cur,
    output regStateT memNext,
    output logic     branchTaken
);

    dataT       ram [ramDepth];
    dataT       rdData;
    dataT       selReg;
    dataT       incRes;
    dataT       newVal;
    logic       storeEn;
    logic [2:0] flagBits;
    logic [2:0] mask;
    logic       condMet;

    assign rdData = ram[instr.mem.addr];
    assign selReg = instr.mem.regSel ? cur.b : cur.a;
    assign incRes = selReg + dataT'(instr.mem.addr);

    // Class bits sit at 15-14 in every format
    assign storeEn = (instr.flg.cls == clsMem) && (instr.mem.memOp == memStore);

    always_ff @(posedge clk) begin
        if (storeEn) begin
            ram[instr.mem.addr] <= selReg;
        end
    end

    always_comb begin
        memNext = cur;
        newVal  = selReg;
        case (instr.mem.memOp)
            memLoad: begin
                if (!instr.mem.mode[2]) begin
                    newVal = rdData;
                end else if (!instr.mem.mode[1]) begin
                    newVal = {selReg[dataWidth-1:addrWidth], instr.mem.addr};
                end else begin
                    newVal = {instr.mem.addr, selReg[addrWidth-1:0]};
                end
            end
            // Carry left alone
            memInc: begin
                newVal        = incRes;
                memNext.flags = resultFlags(incRes, cur.flags.c);
            end
            default: begin
                newVal = selReg;
            end
        endcase
        if (instr.mem.regSel) begin
            memNext.b = newVal;
        end else begin
            memNext.a = newVal;
        end
    end

    // Mode field doubles as the z/n/c mask for branches
    assign flagBits = cur.flags;
    assign mask     = instr.mem.mode;

    always_comb begin
        if (instr.mem.regSel) begin
            // Branch on any masked flag clear
            condMet = (|(mask & ~flagBits)) || (mask == 3'b111);
        end else begin
            condMet = (|(mask & flagBits)) || (mask == 3'b000);
        end
    end

    assign branchTaken = (instr.mem.memOp == memBranch) && condMet;

endmodule

`default_nettype wire

// File: design/sMachine.sv
/*
 * Accumulator machine top. Executes the externally supplied
 * instruction at pc in a single cycle
 */
`timescale 1ns/1ps
`default_nettype none

module sMachine import sMachinePkg::*; (
    input  logic  clk,
    input  logic  rstN,
    input  instrT instr,
    output addrT  pc,
    output dataT  regA,
    output dataT  regB,
    output flagsT flags
);

    regStateT cur;
    regStateT aluNext;
    regStateT flagNext;
    regStateT memNext;
    logic     branchTaken;

    fetchUnit fetchUnit_inst (
        .clk         (clk),
        .rstN        (rstN),
        .instr       (instr),
        .branchTaken (branchTaken),
        .pc          (pc)
    );

    // One proposal per instruction class
    aluUnit aluUnit_inst (
        .instr   (instr),
        .cur     (cur),
        .aluNext (aluNext)
    );

    flagUnit flagUnit_inst (
        .instr    (instr),
        .cur      (cur),
        .flagNext (flagNext)
    );

    memUnit memUnit_inst (
        .clk         (clk),
        .instr       (instr),
        .cur         (cur),
        .memNext     (memNext),
        .branchTaken (branchTaken)
    );

    writebackSelect writebackSelect_inst (
        .clk      (clk),
        .rstN     (rstN),
        .instr    (instr),
        .aluNext  (aluNext),
        .flagNext (flagNext),
        .memNext  (memNext),
        .cur      (cur)
    );

    assign regA  = cur.a;
    assign regB  = cur.b;
    assign flags = cur.flags;

endmodule

`default_nettype wire

// File: design/sMachinePkg.sv
/*
 * Shared definitions for the 16-bit accumulator machine: widths, opcodes,
 * the instruction word formats and the architectural state
 */
`default_nettype none

package sMachinePkg;

    localparam int dataWidth = 16;
    localparam int addrWidth = 8;
    localparam int ramDepth  = 256;

    typedef logic [dataWidth-1:0] dataT;
    typedef logic [addrWidth-1:0] addrT;

    typedef struct packed {
        logic z;
        logic n;
        logic c;
    } flagsT;

    typedef struct packed {
        dataT  a;
        dataT  b;
        flagsT flags;
    } regStateT;

    // Instruction class, bits 15-14
    localparam logic [1:0] clsMem   = 2'b00;
    localparam logic [1:0] clsAluLo = 2'b01;
    localparam logic [1:0] clsAluHi = 2'b10;
    localparam logic [1:0] clsFlag  = 2'b11;

    typedef enum logic [2:0] {
        aluXor  = 3'b000,
        aluShr  = 3'b001,
        aluMov  = 3'b010,
        aluExch = 3'b011,
        aluAdd  = 3'b100,
        aluSub  = 3'b101,
        aluOr   = 3'b110,
        aluAnd  = 3'b111
    } aluOpE;

    typedef enum logic [1:0] {
        flagCmp    = 2'b00,
        flagSet    = 2'b01,
        flagClr    = 2'b10,
        flagClrAll = 2'b11
    } flagOpE;

    // Codes 0100..1111 do not occur here, the class bits would differ
    typedef enum logic [3:0] {
        memLoad   = 4'b0000,
        memStore  = 4'b0001,
        memInc    = 4'b0010,
        memBranch = 4'b0011
    } memOpE;

    typedef struct packed {
        logic        cls1;
        aluOpE       aluOp;
        logic [11:0] unused;
    } instrAluT;

    typedef struct packed {
        logic [1:0] cls;
        flagOpE     flagOp;
        logic       spare;
        flagsT      mask;
        logic [7:0] unused;
    } instrFlagT;

    typedef struct packed {
        memOpE      memOp;
        logic       regSel;
        logic [2:0] mode;
        addrT       addr;
    } instrMemT;

    typedef union packed {
        instrAluT  alu;
        instrFlagT flg;
        instrMemT  mem;
    } instrT;

    // z and n from the result, carry supplied by the caller
    function automatic flagsT resultFlags(input dataT res, input logic carry);
        flagsT f;
        f.z = (res == '0);
        f.n = res[dataWidth-1];
        f.c = carry;
        return f;
    endfunction

    // Carry is the majority of the three MSBs
    function automatic flagsT arithFlags(input dataT op1, input dataT op2, input dataT res);
        logic m1;
        logic m2;
        logic mr;
        m1 = op1[dataWidth-1];
        m2 = op2[dataWidth-1];
        mr = res[dataWidth-1];
        return resultFlags(res, (m1 & m2) | (m1 & mr) | (m2 & mr));
    endfunction

endpackage

`default_nettype wire

// File: design/writebackSelect.sv
/*
 * Picks the next architectural state by instruction class and
 * holds A, B and the flags
 */
`timescale 1ns/1ps
`default_nettype none

module writebackSelect import sMachinePkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  instrT    instr,
    input  regStateT aluNext,
    input  regStateT flagNext,
    input  regStateT memNext,
    output regStateT cur
);

    regStateT nextState;

    always_comb begin
        case (instr.flg.cls)
            clsMem: begin
                nextState = memNext;
            end
            clsAluLo, clsAluHi: begin
                nextState = aluNext;
            end
            clsFlag: begin
                nextState = flagNext;
            end
        endcase
    end

    // A, B and flags
    always_ff @(posedge clk) begin
        if (!rstN) begin
            cur <= '0;
        end else begin
            cur <= nextState;
        end
    end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the accumulator machine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module sMachineTb -Mdir obj_dir -f sources.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/VsMachineTb
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation run exited with status $status"
    exit "$status"
fi

exit 0

// File: sources.f
design/sMachinePkg.sv
design/fetchUnit.sv
design/aluUnit.sv
design/flagUnit.sv
design/memUnit.sv
design/writebackSelect.sv
design/sMachine.sv
test/sMachineProps.sv
test/sMachineTb.sv

// File: test/sMachineProps.sv
/*
 * Concurrent checks on the accumulator machine: pc stepping,
 * carry after logic operations and flags after reset
 */
`timescale 1ns/1ps
`default_nettype none

module sMachineProps import sMachinePkg::*; (
    input logic  clk,
    input logic  rstN,
    input instrT instr,
    input addrT  pc,
    input flagsT flags
);

    logic aluClass;
    logic logicOp;

    assign aluClass = (instr.flg.cls == clsAluLo) || (instr.flg.cls == clsAluHi);
    assign logicOp  = aluClass && ((instr.alu.aluOp == aluOr) ||
        (instr.alu.aluOp == aluAnd) || (instr.alu.aluOp == aluXor));

    // Sampled pc is the result of the previous edge
    pcStep: assert property (@(posedge clk)
        $past(rstN) |-> (pc == addrT'($past(pc) + 8'd1)) || (pc == $past(instr.mem.addr)))
        else $error("pc neither stepped by one nor took the branch target");

    logicCarry: assert property (@(posedge clk)
        (rstN && logicOp) |=> !flags.c)
        else $error("carry set after a bitwise operation");

    resetFlags: assert property (@(posedge clk)
        !rstN |=> (flags == flagsT'(0)))
        else $error("flags not cleared by reset");

endmodule

bind sMachine sMachineProps sMachineProps_inst (
    .clk   (clk),
    .rstN  (rstN),
    .instr (instr),
    .pc    (pc),
    .flags (flags)
);

`default_nettype wire

// File: test/sMachineTb.sv
/*
 * Testbench for the accumulator machine with random program memory,
 * a reference model of every instruction and per-cycle state checks
 */
`timescale 1ns/1ps
`default_nettype none

module sMachineTb import sMachinePkg::*; ();

    localparam int clkPeriod   = 10;
    localparam int resetCycles = 3;
    localparam int numInstr    = 2000;
    localparam int progDepth   = 256;
    localparam int watchdogNs  = (numInstr + resetCycles + 100) * clkPeriod;

    typedef struct packed {
        addrT     pc;
        regStateT regs;
    } archT;

    logic        clk;
    logic        rstN;
    instrT       instr;
    addrT        pc;
    dataT        regA;
    dataT        regB;
    flagsT       flags;

    logic [15:0] progMem [progDepth];
    dataT        refRam [ramDepth];
    bit          refValid [ramDepth];
    archT        model;
    archT        expQ [$];
    logic [31:0] lfsrState;

    sMachine sMachine_inst (
        .clk   (clk),
        .rstN  (rstN),
        .instr (instr),
        .pc    (pc),
        .regA  (regA),
        .regB  (regB),
        .flags (flags)
    );

    always #(clkPeriod / 2) clk = ~clk;

    task automatic stopRun(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic checkAddr(input string name, input addrT got, input addrT want);
        if (got !== want) begin
            stopRun($sformatf("error: time %0t %s got %h expected %h", $time, name, got, want));
        end
    endtask

    task automatic checkData(input string name, input dataT got, input dataT want);
        if (got !== want) begin
            stopRun($sformatf("error: time %0t %s got %h expected %h", $time, name, got, want));
        end
    endtask

    task automatic checkFlags(input string name, input flagsT got, input flagsT want);
        if (got !== want) begin
            stopRun($sformatf("error: time %0t %s got %b expected %b", $time, name, got, want));
        end
    endtask

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic takeBits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            v = {v[14:0], lfsrState[0]};
        end
    endtask

    // Carry is the majority of the two operand MSBs and the result MSB
    function automatic logic msbMajority(input logic x, input logic y, input logic r);
        return (x & y) | (x & r) | (y & r);
    endfunction

    // Mostly ALU words with loads only from addresses stored earlier in the program
    task automatic buildProgram();
        logic [15:0] w;
        logic [15:0] kind;
        bit          stored [ramDepth];
        for (int i = 0; i < ramDepth; i++) begin
            stored[i] = 1'b0;
        end
        for (int p = 0; p < progDepth; p++) begin
            takeBits(16, w);
            takeBits(3, kind);
            if (kind[2:0] < 3'd4) begin
                w[15:14] = w[14] ? 2'b01 : 2'b10;
            end else if (kind[2:0] == 3'd4) begin
                w[15:14] = 2'b11;
            end else begin
                w[15:14] = 2'b00;
                // Small address window so loads hit stored words
                if (w[13:12] == 2'b01 || (w[13:12] == 2'b00 && !w[10])) begin
                    w[7:4] = 4'h0;
                end
                if (w[13:12] == 2'b01) begin
                    stored[w[7:0]] = 1'b1;
                end else if (w[13:12] == 2'b00 && !w[10] && !stored[w[7:0]]) begin
                    w[10] = 1'b1;
                end
            end
            progMem[p] = w;
        end
    endtask

    function automatic archT refExec(input archT s, input logic [15:0] w, input dataT ramRd);
        archT       nx;
        dataT       a;
        dataT       b;
        dataT       sel;
        dataT       res;
        logic [2:0] f;
        logic [2:0] mask;
        logic       taken;
        nx    = s;
        nx.pc = s.pc + 8'd1;
        a     = s.regs.a;
        b     = s.regs.b;
        f     = s.regs.flags;
        mask  = w[10:8];
        case (w[15:14])
            2'b00: begin
                sel = w[11] ? b : a;
                res = sel;
                case (w[13:12])
                    2'b00: begin
                        if (!w[10]) begin
                            res = ramRd;
                        end else if (!w[9]) begin
                            res = {sel[15:8], w[7:0]};
                        end else begin
                            res = {w[7:0], sel[7:0]};
                        end
                    end
                    2'b10: begin
                        res = sel + {8'h00, w[7:0]};
                        nx.regs.flags.z = (res == '0);
                        nx.regs.flags.n = res[15];
                    end
                    2'b11: begin
                        if (w[11]) begin
                            taken = (|(mask & ~f)) || (mask == 3'b111);
                        end else begin
                            taken = (|(mask & f)) || (mask == 3'b000);
                        end
                        if (taken) begin
                            nx.pc = w[7:0];
                        end
                    end
                    default: begin
                    end
                endcase
                if (w[11]) begin
                    nx.regs.b = res;
                end else begin
                    nx.regs.a = res;
                end
            end
            2'b11: begin
                case (w[13:12])
                    2'b00: begin
                        res = a - b;
                        nx.regs.flags = {res == '0, res[15], msbMajority(a[15], b[15], res[15])};
                    end
                    2'b01: nx.regs.flags = f | mask;
                    2'b10: nx.regs.flags = f & ~mask;
                    default: nx.regs.flags = '0;
                endcase
            end
            default: begin
                case (w[14:12])
                    3'b100, 3'b101: begin
                        res = (w[12] == 1'b0) ? a + b : a - b;
                        nx.regs.a = res;
                        nx.regs.flags = {res == '0, res[15], msbMajority(a[15], b[15], res[15])};
                    end
                    3'b110, 3'b111, 3'b000: begin
                        if (w[14:12] == 3'b110) begin
                            res = a | b;
                        end else if (w[14:12] == 3'b111) begin
                            res = a & b;
                        end else begin
                            res = a ^ b;
                        end
                        nx.regs.a = res;
                        nx.regs.flags = {res == '0, res[15], 1'b0};
                    end
                    3'b001: nx.regs.a = {a[0], a[15:1]};
                    3'b010: nx.regs.b = a;
                    default: begin
                        nx.regs.a = b;
                        nx.regs.b = a;
                    end
                endcase
            end
        endcase
        return nx;
    endfunction

    // Drives the word at the DUT's pc and queues the state it must reach
    task automatic issueNext();
        logic [15:0] w;
        archT        nx;
        w = progMem[pc];
        // A branch can reach a load before its store so the immediate form is used then
        if (w[15:12] == 4'b0000 && !w[10] && !refValid[w[7:0]]) begin
            w[10] = 1'b1;
            progMem[pc] = w;
        end
        instr = w;
        nx = refExec(model, w, refRam[w[7:0]]);
        if (w[15:12] == 4'b0001) begin
            refRam[w[7:0]]   = w[11] ? model.regs.b : model.regs.a;
            refValid[w[7:0]] = 1'b1;
        end
        expQ.push_back(nx);
        model = nx;
    endtask

    initial begin : stimulus
        clk       = 1'b0;
        rstN      = 1'b0;
        instr     = '0;
        lfsrState = 32'hde8a_94cd;
        model     = '0;
        for (int i = 0; i < ramDepth; i++) begin
            refValid[i] = 1'b0;
        end
        buildProgram();
        repeat (resetCycles) @(negedge clk);
        checkAddr("pc", pc, '0);
        checkData("regA", regA, '0);
        checkData("regB", regB, '0);
        checkFlags("flags", flags, '0);
        rstN = 1'b1;
        for (int k = 0; k < numInstr; k++) begin
            if (k != 0) begin
                @(negedge clk);
            end
            issueNext();
        end
    end

    initial begin : compare
        archT want;
        int   checked;
        checked = 0;
        wait (rstN === 1'b1);
        while (checked < numInstr) begin
            @(posedge clk);
            @(negedge clk);
            want = expQ.pop_front();
            checkAddr("pc", pc, want.pc);
            checkData("regA", regA, want.regs.a);
            checkData("regB", regB, want.regs.b);
            checkFlags("flags", flags, want.regs.flags);
            checked++;
        end
        $display("Simulation completed successfully");
        $finish;
    end

    initial begin : watchdog
        #(watchdogNs);
        stopRun($sformatf("watchdog expired after %0d ns before all checks ran", watchdogNs));
    end

endmodule

`default_nettype wire
